/* src/cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// **************************************************************************
// cache geometry
// **************************************************************************

`define CACHE_INDEX_W   7     // set index bits.
`define CACHE_OFFSET_W  5     // byte offset within a line.
`define CACHE_TAG_W     20    // 32 - index - offset.
`define CACHE_SETS      128
`define CACHE_LINE_W    256   // 32 bytes per line.

`endif

/* src/cache_types_pkg.sv */
`include "cache_config.svh"

package cache_types_pkg;

    // one full cache line and its byte enables.
    typedef logic [`CACHE_LINE_W-1:0]   line_t;
    typedef logic [`CACHE_LINE_W/8-1:0] line_be_t;

    // address fields.
    typedef logic [`CACHE_INDEX_W-1:0]    index_t;
    typedef logic [`CACHE_TAG_W-1:0]      tag_t;
    typedef logic [`CACHE_OFFSET_W-3:0]   word_sel_t;   // 32-bit word in the line.

    // tag store entry, valid in the top bit.
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

endpackage

/* src/cache_ctrl_pkg.sv */
package cache_ctrl_pkg;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } req_op_e;

    typedef enum logic [1:0] {
        ST_RUN    = 2'd0,   // lookups and hits.
        ST_EVICT  = 2'd1,   // dirty victim going out.
        ST_REFILL = 2'd2,   // waiting on the new line.
        ST_REPLAY = 2'd3    // answer the missed request.
    } ctrl_state_e;

endpackage

/* src/array_if.sv */
`timescale 1ns/1ps

interface array_if #(
    parameter type data_t = cache_types_pkg::line_t,
    parameter type wen_t  = cache_types_pkg::line_be_t
);
    import cache_types_pkg::*;

    index_t rindex;
    index_t windex;
    wen_t   wen;
    data_t  wdata;
    data_t  rdata;   // entry at rindex, one cycle later.

    modport ctrl (output rindex, output windex, output wen, output wdata, input rdata);

    modport array (input rindex, input windex, input wen, input wdata, output rdata);

endinterface

/* src/data_array.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module data_array (
    input  logic   clk,
    array_if.array bus
);
    import cache_types_pkg::*;

    line_t    mem [`CACHE_SETS];
    line_t    ram_q;
    line_t    wdata_q;
    line_be_t wen_q;
    logic     col_q;
    line_t    fwd_line;

    // **********************************************************************
    // line RAM, one read port and one byte-enabled write port
    // **********************************************************************

    always_ff @(posedge clk) begin
        for (int b = 0; b < `CACHE_LINE_W/8; b++) begin
            if (bus.wen[b]) begin
                mem[bus.windex][b*8 +: 8] <= bus.wdata[b*8 +: 8];
            end
        end
        ram_q <= mem[bus.rindex];   // read-first.
    end

    // **********************************************************************
    // same-cycle write/read forwarding
    // **********************************************************************

    always_ff @(posedge clk) begin
        col_q   <= (bus.rindex == bus.windex) && (|bus.wen);
        wen_q   <= bus.wen;
        wdata_q <= bus.wdata;
    end

    always_comb begin
        for (int b = 0; b < `CACHE_LINE_W/8; b++) begin
            fwd_line[b*8 +: 8] = wen_q[b] ? wdata_q[b*8 +: 8] : ram_q[b*8 +: 8];
        end
    end

    assign bus.rdata = col_q ? fwd_line : ram_q;

endmodule

/* src/tag_array.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module tag_array (
    input  logic   clk,
    input  logic   rst_n,
    array_if.array bus
);
    import cache_types_pkg::*;

    logic [`CACHE_TAG_W:0]  ram [`CACHE_SETS];   // {dirty, tag}.
    logic [`CACHE_TAG_W:0]  ram_q;
    logic [`CACHE_SETS-1:0] valid_q;
    logic                   valid_rd_q;
    logic                   col_q;
    tag_entry_t             wdata_q;

    always_ff @(posedge clk) begin
        if (bus.wen) begin
            ram[bus.windex] <= {bus.wdata.dirty, bus.wdata.tag};
        end
        ram_q   <= ram[bus.rindex];
        wdata_q <= bus.wdata;
    end

    // valid bits live in flops so reset empties the cache.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q    <= '0;
            valid_rd_q <= 1'b0;
            col_q      <= 1'b0;
        end else begin
            if (bus.wen) begin
                valid_q[bus.windex] <= bus.wdata.valid;
            end
            valid_rd_q <= valid_q[bus.rindex];
            col_q      <= bus.wen && (bus.rindex == bus.windex);
        end
    end

    // single write enable, so a collision forwards the whole entry.
    assign bus.rdata = col_q ? wdata_q : tag_entry_t'({valid_rd_q, ram_q});

endmodule

/* src/word_steer.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module word_steer (
    input  cache_types_pkg::word_sel_t addr_word,
    input  logic [31:0]                wdata,
    input  logic [3:0]                 be,
    input  cache_types_pkg::line_t     line_in,
    input  logic                       store_en,
    input  logic                       refill_en,
    input  cache_types_pkg::line_t     refill_line,
    output cache_types_pkg::line_t     line_wdata,
    output cache_types_pkg::line_be_t  line_wen,
    output logic [31:0]                rdata
);

    assign rdata = line_in[{addr_word, 5'b0} +: 32];

    always_comb begin
        line_wdata = refill_en ? refill_line : {(`CACHE_LINE_W/32){wdata}};
        line_wen   = {(`CACHE_LINE_W/8){refill_en}};   // refill writes every byte.
        for (int b = 0; b < 4; b++) begin
            if (store_en && be[b]) begin
                line_wdata[{addr_word, 5'b0} + b*8 +: 8] = wdata[b*8 +: 8];
                if (!refill_en) begin
                    line_wen[{addr_word, 2'b00} + b] = 1'b1;
                end
            end
        end
    end

endmodule

/* src/cache_ctrl.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_ctrl (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   req,
    input  cache_ctrl_pkg::req_op_e                op,
    input  logic [31:0]                            addr,
    input  logic [31:0]                            wdata,
    input  logic [3:0]                             be,
    output logic                                   ready,
    output logic                                   resp_valid,
    output logic                                   mem_req,
    output logic                                   mem_we,
    output logic [`CACHE_TAG_W+`CACHE_INDEX_W-1:0] mem_addr,
    input  logic                                   mem_ack,
    array_if.ctrl                                  data_bus,
    array_if.ctrl                                  tag_bus,
    input  cache_types_pkg::line_t                 line_wdata,
    input  cache_types_pkg::line_be_t              line_wen,
    output cache_types_pkg::word_sel_t             word_sel,
    output logic [31:0]                            store_wdata,
    output logic [3:0]                             store_be,
    output logic                                   store_en,
    output logic                                   refill_en
);
    import cache_types_pkg::*;
    import cache_ctrl_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    logic        lk_valid_q;
    req_op_e     lk_op_q;
    tag_t        lk_tag_q;
    index_t      lk_index_q;
    word_sel_t   lk_word_q;
    logic [31:0] lk_wdata_q;
    logic [3:0]  lk_be_q;

    logic        lk_store;
    logic        tag_hit;
    logic        run_hit;
    logic        run_miss;
    index_t      rd_index;

    // **********************************************************************
    // lookup stage
    // **********************************************************************

    assign lk_store = (lk_op_q == OP_STORE);
    assign tag_hit  = tag_bus.rdata.valid && (tag_bus.rdata.tag == lk_tag_q);
    assign run_hit  = (state_q == ST_RUN) && lk_valid_q && tag_hit;
    assign run_miss = (state_q == ST_RUN) && lk_valid_q && !tag_hit;

    assign ready      = ((state_q == ST_RUN) && !run_miss) || (state_q == ST_REPLAY);
    assign resp_valid = run_hit || (state_q == ST_REPLAY);

    // while stalled keep reading the missed set, victim stays on rdata.
    assign rd_index = ready ? addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W] : lk_index_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= ST_RUN;
            lk_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (ready) begin
                lk_valid_q <= req;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && ready) begin
            lk_op_q    <= op;
            lk_tag_q   <= addr[31 -: `CACHE_TAG_W];
            lk_index_q <= addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
            lk_word_q  <= addr[2 +: `CACHE_OFFSET_W-2];
            lk_wdata_q <= wdata;
            lk_be_q    <= be;
        end
    end

    // **********************************************************************
    // miss sequencing
    // **********************************************************************

    assign mem_we   = (run_miss && tag_bus.rdata.valid && tag_bus.rdata.dirty) ||
                      (state_q == ST_EVICT);
    assign mem_req  = run_miss || (state_q == ST_EVICT) || (state_q == ST_REFILL);
    assign mem_addr = mem_we ? {tag_bus.rdata.tag, lk_index_q} : {lk_tag_q, lk_index_q};

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_RUN: begin
                if (run_miss && mem_we) begin
                    state_d = mem_ack ? ST_REFILL : ST_EVICT;
                end else if (run_miss) begin
                    state_d = mem_ack ? ST_REPLAY : ST_REFILL;
                end
            end
            ST_EVICT: begin
                if (mem_ack) begin
                    state_d = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (mem_ack) begin
                    state_d = ST_REPLAY;
                end
            end
            default: state_d = ST_RUN;   // replay lasts one cycle.
        endcase
    end

    // refilled line lands on the ack, replay then reads it back forwarded.
    assign refill_en = mem_req && !mem_we && mem_ack;
    assign store_en  = lk_store && (run_hit || refill_en);

    assign word_sel    = lk_word_q;
    assign store_wdata = lk_wdata_q;
    assign store_be    = lk_be_q;

    assign data_bus.rindex = rd_index;
    assign data_bus.windex = lk_index_q;
    assign data_bus.wen    = line_wen;
    assign data_bus.wdata  = line_wdata;

    assign tag_bus.rindex = rd_index;
    assign tag_bus.windex = lk_index_q;
    assign tag_bus.wen    = (run_hit && lk_store) || refill_en;
    assign tag_bus.wdata  = {1'b1, lk_store, lk_tag_q};   // valid, dirty on store.

endmodule

/* src/dcache_top.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module dcache_top (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   req,
    input  cache_ctrl_pkg::req_op_e                op,
    input  logic [31:0]                            addr,
    input  logic [31:0]                            wdata,
    input  logic [3:0]                             be,
    output logic                                   ready,
    output logic                                   resp_valid,
    output logic [31:0]                            rdata,
    output logic                                   mem_req,
    output logic                                   mem_we,
    output logic [`CACHE_TAG_W+`CACHE_INDEX_W-1:0] mem_addr,
    output cache_types_pkg::line_t                 mem_wdata,
    input  logic                                   mem_ack,
    input  cache_types_pkg::line_t                 mem_rdata
);
    import cache_types_pkg::*;

    array_if #(.data_t(line_t), .wen_t(line_be_t)) data_bus ();
    array_if #(.data_t(tag_entry_t), .wen_t(logic)) tag_bus ();

    word_sel_t   word_sel;
    logic [31:0] store_wdata;
    logic [3:0]  store_be;
    logic        store_en;
    logic        refill_en;
    line_t       line_wdata;
    line_be_t    line_wen;

    assign mem_wdata = data_bus.rdata;   // victim line held on the read port.

    cache_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .op          (op),
        .addr        (addr),
        .wdata       (wdata),
        .be          (be),
        .ready       (ready),
        .resp_valid  (resp_valid),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_ack     (mem_ack),
        .data_bus    (data_bus.ctrl),
        .tag_bus     (tag_bus.ctrl),
        .line_wdata  (line_wdata),
        .line_wen    (line_wen),
        .word_sel    (word_sel),
        .store_wdata (store_wdata),
        .store_be    (store_be),
        .store_en    (store_en),
        .refill_en   (refill_en)
    );

    data_array u_data (
        .clk (clk),
        .bus (data_bus.array)
    );

    tag_array u_tag (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (tag_bus.array)
    );

    word_steer u_steer (
        .addr_word   (word_sel),
        .wdata       (store_wdata),
        .be          (store_be),
        .line_in     (data_bus.rdata),
        .store_en    (store_en),
        .refill_en   (refill_en),
        .refill_line (mem_rdata),
        .line_wdata  (line_wdata),
        .line_wen    (line_wen),
        .rdata       (rdata)
    );

endmodule

/* verif/dcache_props.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module dcache_props (
    input logic                                   clk,
    input logic                                   rst_n,
    input logic                                   req,
    input logic                                   ready,
    input logic                                   resp_valid,
    input logic                                   mem_req,
    input logic                                   mem_we,
    input logic [`CACHE_TAG_W+`CACHE_INDEX_W-1:0] mem_addr,
    input logic                                   mem_ack
);

    logic pending_q;   // a request was accepted and is not answered yet.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
        end else if (req && ready) begin
            pending_q <= 1'b1;
        end else if (resp_valid) begin
            pending_q <= 1'b0;
        end
    end

    mem_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_ack |=> mem_req && $stable(mem_addr) && $stable(mem_we))
        else $error("memory request dropped or changed before its ack");

    ready_low_on_mem: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |-> !ready)
        else $error("ready high while a memory request is open");

    resp_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> pending_q)
        else $error("response pulse without an accepted request");

    reset_values: assert property (@(posedge clk)
        $rose(rst_n) |-> ready && !resp_valid && !mem_req && !mem_we)
        else $error("outputs not idle after reset");

endmodule

bind cache_ctrl dcache_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .ready      (ready),
    .resp_valid (resp_valid),
    .mem_req    (mem_req),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_ack    (mem_ack)
);

/* verif/dcache_tb.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module dcache_tb;
    import cache_types_pkg::*;
    import cache_ctrl_pkg::*;

    localparam int N_DIRECTED  = 9;
    localparam int N_RANDOM    = 600;
    localparam int N_DRAIN_MAX = `CACHE_SETS;
    localparam int TIMEOUT     = 40 * (N_DIRECTED + N_RANDOM + N_DRAIN_MAX) + 100;
    localparam int MEM_LINES   = 512;   // 16 KB window.

    typedef struct packed {
        logic        is_load;
        logic        hit;
        logic [31:0] data;
        logic [31:0] acc_cycle;
    } expect_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        req;
    req_op_e     op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic        ready;
    logic        resp_valid;
    logic [31:0] rdata;
    logic        mem_req;
    logic        mem_we;
    logic [26:0] mem_addr;
    line_t       mem_wdata;
    logic        mem_ack;
    line_t       mem_rdata;

    logic [31:0] cycle      = '0;
    logic [31:0] stim_state = 32'd41;
    logic [31:0] lat_state  = 32'd41;

    logic [7:0]  shadow [16384];
    line_t       mem_lines [MEM_LINES];
    logic        model_valid [`CACHE_SETS];
    tag_t        model_tag [`CACHE_SETS];
    expect_t     exp_q [$];

    always #2 clk = ~clk;

    dcache_top u_dcache_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .op         (op),
        .addr       (addr),
        .wdata      (wdata),
        .be         (be),
        .ready      (ready),
        .resp_valid (resp_valid),
        .rdata      (rdata),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata)
    );

    // **********************************************************************
    // helpers
    // **********************************************************************

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_step(state);
            v     = {v[30:0], state[0]};
        end
    endtask

    function automatic logic [7:0] fill_byte(input int unsigned a);
        return 8'(a * 157) ^ 8'(a >> 6) ^ 8'(a >> 11);
    endfunction

    // reference model over a flat byte shadow with little-endian lanes.
    function automatic logic [31:0] expected_word(input req_op_e o, input logic [31:0] a,
                                                  input logic [31:0] d, input logic [3:0] b);
        int unsigned base;
        base = 32'({a[13:2], 2'b00});
        for (int i = 0; i < 4; i++) begin
            if (o == OP_STORE && b[i]) begin
                shadow[base + i] = d[i*8 +: 8];
            end
        end
        return {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
    endfunction

    // present a request and hold it until ready.
    task automatic issue(input req_op_e o, input logic [31:0] a, input logic [31:0] d,
                         input logic [3:0] b);
        expect_t e;
        index_t  set;
        req   = 1'b1;
        op    = o;
        addr  = a;
        wdata = d;
        be    = b;
        while (!ready) begin
            @(negedge clk);
        end
        set         = a[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
        e.is_load   = (o == OP_LOAD);
        e.hit       = model_valid[set] && (model_tag[set] == a[31:12]);
        e.data      = expected_word(o, a, d, b);
        e.acc_cycle = cycle + 1;   // taken on the coming rising edge.
        model_valid[set] = 1'b1;
        model_tag[set]   = a[31:12];
        exp_q.push_back(e);
        @(negedge clk);
        req = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic check_line(input int unsigned l);
        line_t want;
        for (int i = 0; i < 32; i++) begin
            want[i*8 +: 8] = shadow[l*32 + i];
        end
        assert (mem_lines[l] == want) else stop_on_error($sformatf(
            "Error at time %0t: memory line %0d holds %h, expected %h",
            $time, l, mem_lines[l], want));
    endtask

    // **********************************************************************
    // memory model answering after 1 to 6 cycles
    // **********************************************************************

    initial begin : memory_model
        logic        busy;
        int unsigned wait_left;
        logic [31:0] lat;
        busy      = 1'b0;
        wait_left = 0;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        for (int l = 0; l < MEM_LINES; l++) begin
            for (int i = 0; i < 32; i++) begin
                mem_lines[l][i*8 +: 8] = fill_byte(l*32 + i);
            end
        end
        forever begin
            @(negedge clk);
            mem_ack = 1'b0;
            if (busy && wait_left == 0) begin
                if (mem_we) begin
                    mem_lines[mem_addr[8:0]] = mem_wdata;
                end else begin
                    mem_rdata = mem_lines[mem_addr[8:0]];
                end
                mem_ack = 1'b1;
                busy    = 1'b0;
            end else if (busy) begin
                wait_left--;
            end else if (mem_req) begin
                assert (mem_addr < MEM_LINES)
                    else stop_on_error("memory address outside the 16 KB test window");
                draw_bits(lat_state, 3, lat);
                wait_left = lat % 6;
                busy      = 1'b1;
            end
        end
    end

    // **********************************************************************
    // response checker and timeout
    // **********************************************************************

    initial begin : compare_responses
        expect_t e;
        forever begin
            @(negedge clk);
            #1;
            if (resp_valid) begin
                assert (exp_q.size() != 0)
                    else stop_on_error("response pulse with no request outstanding");
                e = exp_q.pop_front();
                assert (ready) else stop_on_error("ready low in a response cycle");
                if (e.hit) begin
                    assert (cycle == e.acc_cycle) else stop_on_error($sformatf(
                        "Error at time %0t: hit answered %0d cycles after acceptance",
                        $time, cycle - e.acc_cycle + 1));
                end
                if (e.is_load) begin
                    assert (rdata == e.data) else stop_on_error($sformatf(
                        "Error at time %0t: load returned %h, expected %h",
                        $time, rdata, e.data));
                end
            end else if (exp_q.size() != 0) begin
                assert (!exp_q[0].hit || cycle < exp_q[0].acc_cycle)
                    else stop_on_error("hit request got no response one cycle after acceptance");
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            stop_on_error($sformatf("timeout: the run did not finish in %0d cycles", TIMEOUT));
        end
    end

    // **********************************************************************
    // stimulus
    // **********************************************************************

    task automatic run_random();
        logic [31:0] gap;
        logic [31:0] o;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] b;
        for (int n = 0; n < N_RANDOM; n++) begin
            draw_bits(stim_state, 2, gap);
            if (gap == 0) begin
                @(negedge clk);   // idle cycle.
            end
            draw_bits(stim_state, 1, o);
            draw_bits(stim_state, 12, a);
            draw_bits(stim_state, 32, d);
            draw_bits(stim_state, 4, b);
            issue(req_op_e'(o[0]), {18'b0, a[11:0], 2'b00}, d, b[3:0]);
        end
    endtask

    // load a different tag into every valid set so dirty lines go out.
    task automatic run_drain();
        logic [31:0] a;
        for (int s = 0; s < `CACHE_SETS; s++) begin
            if (model_valid[s]) begin
                a = {18'b0, 2'(model_tag[s][1:0] + 2'd1), 7'(s), 5'b0};
                issue(OP_LOAD, a, 32'h0, 4'h0);
            end
        end
    endtask

    initial begin
        rst_n = 1'b0;
        req   = 1'b0;
        op    = OP_LOAD;
        addr  = '0;
        wdata = '0;
        be    = '0;
        for (int i = 0; i < 16384; i++) begin
            shadow[i] = fill_byte(i);
        end
        for (int s = 0; s < `CACHE_SETS; s++) begin
            model_valid[s] = 1'b0;
            model_tag[s]   = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        issue(OP_LOAD,  32'h0000_0100, 32'h0,         4'h0);   // miss that allocates set 8.
        issue(OP_STORE, 32'h0000_0104, 32'hdead_beef, 4'hf);
        issue(OP_LOAD,  32'h0000_0104, 32'h0,         4'h0);   // forwarded store.
        issue(OP_STORE, 32'h0000_0108, 32'h1234_5678, 4'b0101);
        issue(OP_LOAD,  32'h0000_0108, 32'h0,         4'h0);
        issue(OP_STORE, 32'h0000_0108, 32'ha5a5_a5a5, 4'b1000);
        issue(OP_LOAD,  32'h0000_0108, 32'h0,         4'h0);
        issue(OP_LOAD,  32'h0000_0100, 32'h0,         4'h0);
        issue(OP_LOAD,  32'h0000_1104, 32'h0,         4'h0);   // other tag in set 8 evicts.
        wait_idle();
        check_line(8);

        run_random();
        run_drain();
        wait_idle();
        for (int l = 0; l < MEM_LINES; l++) begin
            check_line(l);
        end

        $display("Test OK");
        $finish;
    end

endmodule

/* build.f */
+incdir+src
src/cache_types_pkg.sv
src/cache_ctrl_pkg.sv
src/array_if.sv
src/data_array.sv
src/tag_array.sv
src/word_steer.sv
src/cache_ctrl.sv
src/dcache_top.sv
verif/dcache_props.sv
verif/dcache_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := dcache_tb
FILELIST := build.f
OBJ_DIR  := obj_dir
LOG      := sim.log

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard src/*.svh)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q '^Test OK$$' $(LOG)

check: run
	@echo "pass message found in $(LOG)"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
